//--- hdl/uartBoot_defs.svh
`ifndef UARTBOOT_DEFS_SVH
`define UARTBOOT_DEFS_SVH

// clock cycles per serial bit
// 16 keeps simulation short, raise it for a real baud rate
// (e.g. 27 MHz / 115200 is about 234)
`define CLKS_PER_BIT 16

// instruction memory depth in 32-bit words
// 64 words fills an 8-bit byte address exactly
`define MEM_WORDS 64

`endif

//--- hdl/uartBootPkg.sv
`default_nettype none

package uartBootPkg;

    // data carried on the serial line
    typedef logic [7:0] byteT;

    // one instruction
    typedef logic [31:0] wordT;

    // processor side byte address into instruction memory
    typedef logic [7:0] byteAddrT;

    // word slot in instruction memory
    typedef logic [5:0] wordIndexT;

    // serial receiver
    typedef enum logic [1:0] {IDLE, START, DATA, STOP} rxStateT;

    // boot loader, count byte first, then four bytes per word
    typedef enum logic [2:0] {SIZE, BYTE0, BYTE1, BYTE2, BYTE3, DONE} loadStateT;

endpackage

`default_nettype wire

//--- hdl/uartRx.sv
`default_nettype none

`include "uartBoot_defs.svh"

module uartRx #(
    parameter int ClksPerBit = `CLKS_PER_BIT
) (
    input  wire               clk,
    input  wire               rstN,
    input  wire               serialIn,
    output uartBootPkg::byteT rxByte,
    output logic              rxValid
);
    import uartBootPkg::*;

    localparam int CntWidth = $clog2(ClksPerBit);
    localparam int HalfBit = ClksPerBit / 2;

    logic rxMeta;
    logic rxSync;
    rxStateT state;
    logic [CntWidth-1:0] bitTimer;
    logic [2:0] bitCount;
    logic halfDone;
    logic bitDone;
    byteT shiftReg;

    // line is asynchronous to clk
    always_ff @(posedge clk) begin
        if (!rstN) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
        end else begin
            rxMeta <= serialIn;
            rxSync <= rxMeta;
        end
    end

    assign halfDone = bitTimer == CntWidth'(HalfBit - 1);
    assign bitDone = bitTimer == CntWidth'(ClksPerBit - 1);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
            bitTimer <= '0;
            bitCount <= '0;
            rxValid <= 1'b0;
        end else begin
            rxValid <= 1'b0;
            case (state)
                IDLE: begin
                    bitTimer <= '0;
                    if (!rxSync) begin
                        state <= START;
                    end
                end
                START: begin
                    if (halfDone) begin
                        bitTimer <= '0;
                        bitCount <= '0;
                        // high at mid start bit means a glitch
                        state <= rxSync ? IDLE : DATA;
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                DATA: begin
                    if (bitDone) begin
                        bitTimer <= '0;
                        bitCount <= bitCount + 1'b1;
                        if (bitCount == 3'd7) begin
                            state <= STOP;
                        end
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                STOP: begin
                    if (bitDone) begin
                        bitTimer <= '0;
                        state <= IDLE;
                        // framing error drops the byte
                        rxValid <= rxSync;
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == DATA && bitDone) begin
            shiftReg <= {rxSync, shiftReg[7:1]};
        end
    end

    assign rxByte = shiftReg;

endmodule

`default_nettype wire

//--- hdl/programLoader.sv
`default_nettype none

`include "uartBoot_defs.svh"

module programLoader (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire uartBootPkg::byteT rxByte,
    input  wire                    rxValid,
    output logic                   wrEn,
    output uartBootPkg::wordIndexT wrIndex,
    output uartBootPkg::wordT      wrWord,
    output logic                   cpuEnable
);
    import uartBootPkg::*;

    // one extra bit so a full memory count fits
    localparam int CountWidth = $clog2(`MEM_WORDS) + 1;

    loadStateT state;
    logic [CountWidth-1:0] wordCount;
    logic [CountWidth-1:0] clampedCount;
    wordIndexT wordIndex;
    logic lastWord;
    logic [23:0] holdReg;

    assign clampedCount = (rxByte > byteT'(`MEM_WORDS)) ? CountWidth'(`MEM_WORDS)
                                                        : CountWidth'(rxByte);
    assign lastWord = (CountWidth'(wordIndex) + 1'b1) == wordCount;
    assign wrIndex = wordIndex;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= SIZE;
            wordCount <= '0;
            wordIndex <= '0;
            wrEn <= 1'b0;
            cpuEnable <= 1'b0;
        end else begin
            wrEn <= 1'b0;
            if (wrEn) begin
                wordIndex <= wordIndex + 1'b1;
            end
            // final word is being stored
            if (wrEn && state == DONE) begin
                cpuEnable <= 1'b1;
            end
            if (rxValid) begin
                case (state)
                    SIZE: begin
                        wordCount <= clampedCount;
                        if (clampedCount == '0) begin
                            state <= DONE;
                            cpuEnable <= 1'b1;
                        end else begin
                            state <= BYTE0;
                        end
                    end
                    BYTE0: state <= BYTE1;
                    BYTE1: state <= BYTE2;
                    BYTE2: state <= BYTE3;
                    BYTE3: begin
                        wrEn <= 1'b1;
                        state <= lastWord ? DONE : BYTE0;
                    end
                    default: begin
                        // nothing more to load
                    end
                endcase
            end
        end
    end

    // msb first, the fourth byte goes straight into the word
    always_ff @(posedge clk) begin
        if (rxValid) begin
            if (state inside {BYTE0, BYTE1, BYTE2}) begin
                holdReg <= {holdReg[15:0], rxByte};
            end
            if (state == BYTE3) begin
                wrWord <= {holdReg, rxByte};
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/instructionMemory.sv
`default_nettype none

`include "uartBoot_defs.svh"

module instructionMemory (
    input  wire                         clk,
    input  wire                         wrEn,
    input  wire uartBootPkg::wordIndexT wrIndex,
    input  wire uartBootPkg::wordT      wrWord,
    input  wire uartBootPkg::byteAddrT  address,
    output uartBootPkg::wordT           data
);
    import uartBootPkg::*;

    wordT mem [`MEM_WORDS];

    wordIndexT curIndex;
    wordIndexT nextIndex;
    wordT curWord;
    wordT nextWord;

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrIndex] <= wrWord;
        end
    end

    assign curIndex = address[7:2];
    // last word wraps to the first
    assign nextIndex = curIndex + 1'b1;
    assign curWord = mem[curIndex];
    assign nextWord = mem[nextIndex];

    // four bytes starting at the byte offset, spilling into the next word
    always_comb begin
        case (address[1:0])
            2'd0: data = curWord;
            2'd1: data = {curWord[23:0], nextWord[31:24]};
            2'd2: data = {curWord[15:0], nextWord[31:16]};
            default: data = {curWord[7:0], nextWord[31:8]};
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/uartBoot.sv
`default_nettype none

`include "uartBoot_defs.svh"

module uartBoot #(
    parameter int ClksPerBit = `CLKS_PER_BIT
) (
    input  wire                        clk,
    input  wire                        rstN,
    input  wire                        serialIn,
    input  wire uartBootPkg::byteAddrT address,
    output uartBootPkg::wordT          data,
    output logic                       cpuEnable
);
    import uartBootPkg::*;

    byteT rxByte;
    logic rxValid;
    logic wrEn;
    wordIndexT wrIndex;
    wordT wrWord;

    uartRx #(
        .ClksPerBit(ClksPerBit)
    ) uartRx_i (
        .clk(clk),
        .rstN(rstN),
        .serialIn(serialIn),
        .rxByte(rxByte),
        .rxValid(rxValid)
    );

    programLoader programLoader_i (
        .clk(clk),
        .rstN(rstN),
        .rxByte(rxByte),
        .rxValid(rxValid),
        .wrEn(wrEn),
        .wrIndex(wrIndex),
        .wrWord(wrWord),
        .cpuEnable(cpuEnable)
    );

    // processor reads here once cpuEnable is up
    instructionMemory instructionMemory_i (
        .clk(clk),
        .wrEn(wrEn),
        .wrIndex(wrIndex),
        .wrWord(wrWord),
        .address(address),
        .data(data)
    );

endmodule

`default_nettype wire

//--- tests/uartBootTb.sv
`default_nettype none

`include "uartBoot_defs.svh"

module uartBootTb;
    import uartBootPkg::*;

    localparam int ClkPeriod = 100;
    localparam int BitCycles = `CLKS_PER_BIT;
    // bytes on the line per test in run order are 9, 17, 0, 258, 5 and 33
    localparam int TotalBytes = 322;
    localparam longint WatchdogTime = longint'(TotalBytes) * 10 * BitCycles * ClkPeriod
        + longint'(200) * BitCycles * ClkPeriod;

    logic clk;
    logic rstN;
    logic serialIn;
    byteAddrT address;
    wordT data;
    logic cpuEnable;

    // expected memory contents survive resets like the memory itself
    wordT model [`MEM_WORDS];
    wordT progWords [`MEM_WORDS];
    integer seed;
    int errorCount;
    int checkCount;

    uartBoot dut_i (
        .clk(clk),
        .rstN(rstN),
        .serialIn(serialIn),
        .address(address),
        .data(data),
        .cpuEnable(cpuEnable)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // all tasks below start and end on a falling edge
    task automatic applyReset();
        @(negedge clk);
        rstN = 1'b0;
        repeat (5) @(negedge clk);
        rstN = 1'b1;
    endtask

    task automatic holdBit(input logic level);
        serialIn = level;
        repeat (BitCycles) @(negedge clk);
    endtask

    // 8N1 frame with lsb first
    task automatic sendByte(input byteT value);
        holdBit(1'b0);
        for (int i = 0; i < 8; i++) begin
            holdBit(value[i]);
        end
        holdBit(1'b1);
    endtask

    task automatic sendWord(input int index);
        for (int b = 3; b >= 0; b--) begin
            sendByte(progWords[index][8 * b +: 8]);
        end
        model[index] = progWords[index];
    endtask

    task automatic loadProgram(input byteT count, input int numWords);
        sendByte(count);
        for (int w = 0; w < numWords; w++) begin
            sendWord(w);
        end
    endtask

    task automatic idleLine();
        repeat (2 * BitCycles) @(negedge clk);
    endtask

    // memory seen as a byte stream with the msb of each word first
    function automatic wordT expectedRead(input byteAddrT addr);
        wordT result;
        wordT w;
        int k;
        result = '0;
        for (int n = 0; n < 4; n++) begin
            k = (int'(addr) + n) % 256;
            w = model[k / 4];
            result = {result[23:0], w[31 - 8 * (k % 4) -: 8]};
        end
        return result;
    endfunction

    task automatic checkRead(input byteAddrT addr);
        wordT expected;
        expected = expectedRead(addr);
        address = addr;
        #(ClkPeriod / 4);
        checkCount++;
        assert (data === expected) else begin
            errorCount++;
            $display("[ERROR] %0t data at address %0d: expected %h, got %h",
                $time, addr, expected, data);
        end
        @(negedge clk);
    endtask

    task automatic checkEnable(input logic expected);
        checkCount++;
        assert (cpuEnable === expected) else begin
            errorCount++;
            $display("[ERROR] %0t cpuEnable: expected %b, got %b", $time, expected, cpuEnable);
        end
    endtask

    task automatic waitForEnable();
        int cycles;
        cycles = 0;
        while (cpuEnable !== 1'b1 && cycles < 4 * BitCycles) begin
            @(negedge clk);
            cycles++;
        end
        checkCount++;
        assert (cpuEnable === 1'b1) else begin
            errorCount++;
            $display("cpuEnable did not rise within %0d cycles, at %0t", 4 * BitCycles, $time);
        end
    endtask

    task automatic partialLoad();
        applyReset();
        checkEnable(1'b0);
        progWords[0] = 32'h1234_5678;
        progWords[1] = 32'h9abc_def0;
        loadProgram(8'd3, 2);
        idleLine();
        checkEnable(1'b0);
    endtask

    task automatic fixedLoad();
        applyReset();
        progWords[0] = 32'hdead_beef;
        progWords[1] = 32'h0123_4567;
        progWords[2] = 32'h89ab_cdef;
        progWords[3] = 32'hcafe_f00d;
        loadProgram(8'd4, 4);
        waitForEnable();
        for (int i = 0; i < 4; i++) begin
            checkRead(byteAddrT'(4 * i));
        end
    endtask

    task automatic unalignedReads();
        for (int w = 0; w < 3; w++) begin
            for (int off = 1; off < 4; off++) begin
                checkRead(byteAddrT'(4 * w + off));
            end
        end
    endtask

    // after a full load the write index has wrapped to word 0
    task automatic ignoreAfterDone();
        sendByte(8'h55);
        sendByte(8'haa);
        sendByte(8'h0f);
        sendByte(8'hf0);
        sendByte(8'h33);
        idleLine();
        checkEnable(1'b1);
        for (int a = 0; a < 13; a++) begin
            checkRead(byteAddrT'(a));
        end
    endtask

    task automatic countLimits();
        applyReset();
        sendByte(8'd0);
        waitForEnable();
        applyReset();
        checkEnable(1'b0);
        for (int i = 0; i < `MEM_WORDS; i++) begin
            progWords[i] = {8'(i), 8'(~i), 8'(i * 37), 8'(8'h5a ^ 8'(i))};
        end
        // 200 clamps to a full memory
        loadProgram(8'd200, `MEM_WORDS - 1);
        idleLine();
        checkEnable(1'b0);
        sendWord(`MEM_WORDS - 1);
        waitForEnable();
        checkRead(8'd252);
        checkRead(8'd253);
        checkRead(8'd254);
        checkRead(8'd255);
        checkRead(8'd130);
    endtask

    task automatic randomLoad();
        applyReset();
        for (int i = 0; i < 8; i++) begin
            progWords[i] = $random(seed);
        end
        loadProgram(8'd8, 8);
        waitForEnable();
        for (int a = 0; a < 32; a++) begin
            checkRead(byteAddrT'(a));
        end
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        serialIn = 1'b1;
        address = '0;
        seed = 32'h4654;
        errorCount = 0;
        checkCount = 0;
        partialLoad();
        fixedLoad();
        unalignedReads();
        countLimits();
        ignoreAfterDone();
        randomLoad();
        $display("checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WatchdogTime);
        $display("watchdog expired at %0t with the tests still running, errors so far: %0d",
            $time, errorCount);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- uartBoot.f
+incdir+hdl
hdl/uartBootPkg.sv
hdl/uartRx.sv
hdl/programLoader.sv
hdl/instructionMemory.sv
hdl/uartBoot.sv
tests/uartBootTb.sv

//--- run.sh
#!/bin/sh
# build and run the uartBoot testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module uartBootTb -f uartBoot.f; then
    echo "verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/VuartBootTb); then
    echo "$output"
    echo "simulation exited with an error status"
    exit 1
fi

echo "$output"

if echo "$output" | grep -qF "All tests passed!"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi
